// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := wexCoreTb
FILELIST   := wexCore.f
OBJDIR     := obj_dir
LOG        := sim.log
FAIL_MSG   := Finished with errors
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== bench/wexCoreChecker.sv ====
// WEX core checker that models each window and compares the retire trace and step
`timescale 1ns/1ps
`include "bjxConsts.svh"

module wexCoreChecker (
	input  logic            clock,
	input  logic            rst,
	input  logic            istrValid,
	input  logic [63:0]     istrWord,
	input  logic            srWxe,
	input  logic [3:0]      idStep,
	input  logic            wbValid,
	input  logic            wbEnA,
	input  bjxPkg::regIdx_t wbRegA,
	input  bjxPkg::word_t   wbDataA,
	input  logic            wbEnB,
	input  bjxPkg::regIdx_t wbRegB,
	input  bjxPkg::word_t   wbDataB,
	input  logic            srT,
	output int              errorCount,
	output int              pendingCount
);
	import bjxPkg::*;

	typedef struct packed {
		logic    enA;
		regIdx_t regA;
		word_t   dataA;
		logic    enB;
		regIdx_t regB;
		word_t   dataB;
		logic    nextT;
	} retire_t;

	retire_t       expQ [$];
	retire_t       nextExp;
	retire_t       gotExp;
	logic [3:0]    refStep;
	logic [2047:0] shadowRegs; // 64 words, register 0 never written
	logic          shadowT;
	logic [1:0]    validPipe;

	// One op evaluated against a register image
	function automatic void refOp(input logic [31:0] w, input logic wide,
		input logic [2047:0] regs, input logic tIn, output logic wr, output regIdx_t rn,
		output word_t res, output logic cmpV, output logic cmp);
		logic [5:0] op;
		logic [1:0] cond;
		logic       isImm;
		logic       pass;
		regIdx_t    ra;
		regIdx_t    rb;
		word_t      a;
		word_t      b;
		op    = wide ? ({3'b000, w[10:8]} + 6'd1) : {2'b00, w[15:12]};
		cond  = `JX2_IXC_AL;
		if (wide && w[15:12] == `JX2_PFX_PRED)
			cond = w[11] ? `JX2_IXC_CF : `JX2_IXC_CT;
		isImm = (op == `JX2_OP_MOVI) || (op == `JX2_OP_ADDI);
		rn    = wide ? w[5:0] : {2'b00, w[11:8]};
		ra    = (wide && !isImm) ? w[31:26] : rn;
		rb    = wide ? w[25:20] : {2'b00, w[7:4]};
		a     = regs[{ra, 5'd0} +: 32];
		b     = regs[{rb, 5'd0} +: 32];
		if (isImm)
			b = wide ? {{16{w[31]}}, w[31:16]} : {28'd0, w[3:0]};
		pass = (cond == `JX2_IXC_AL) || (cond == `JX2_IXC_CT && tIn) ||
			(cond == `JX2_IXC_CF && !tIn);
		case (op)
			`JX2_OP_ADD:  res = a + b;
			`JX2_OP_SUB:  res = a - b;
			`JX2_OP_AND:  res = a & b;
			`JX2_OP_OR:   res = a | b;
			`JX2_OP_XOR:  res = a ^ b;
			`JX2_OP_MOVI: res = b;
			`JX2_OP_ADDI: res = a + b;
			default:      res = '0;
		endcase
		wr   = pass && (op >= `JX2_OP_ADD) && (op <= `JX2_OP_ADDI) && (rn != `JX2_GR_ZZR);
		cmpV = pass && (op == `JX2_OP_CMPEQ);
		cmp  = (a == b);
	endfunction

	// Whole window, gives step, retire fields and the next T
	function automatic void predictWindow(input logic [63:0] win, input logic wxe,
		input logic [2047:0] regs, input logic tIn, output logic [3:0] step,
		output retire_t want);
		logic wideA;
		logic wideB;
		logic bundle;
		logic cvA, cA, cvB, cB;
		wideA  = (win[15:12] >= `JX2_PFX_PRED);
		wideB  = (win[47:44] >= `JX2_PFX_PRED);
		bundle = wideA && (win[15:12] == `JX2_PFX_UNC) && win[11] && wideB && wxe;
		step   = bundle ? 4'd8 : (wideA ? 4'd4 : 4'd2);
		want.enB  = 1'b0;
		want.regB = `JX2_GR_ZZR;
		want.dataB = '0;
		cvB = 1'b0;
		cB  = 1'b0;
		if (bundle)
		begin
			// Slot B on lane 1, slot A on lane 2
			refOp(win[63:32], 1'b1, regs, tIn, want.enA, want.regA, want.dataA, cvA, cA);
			refOp(win[31:0], 1'b1, regs, tIn, want.enB, want.regB, want.dataB, cvB, cB);
		end
		else
			refOp(win[31:0], wideA, regs, tIn, want.enA, want.regA, want.dataA, cvA, cA);
		if (want.enA && want.enB && want.regA == want.regB)
			want.enB = 1'b0; // Lane 1 wins
		want.nextT = cvA ? cA : (cvB ? cB : tIn);
	endfunction

	task automatic compareField(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want)
		begin
			$display("FAILED %s got %h expected %h", name, got, want);
			errorCount++;
		end
	endtask

	always @(negedge clock)
	begin
		if (rst)
		begin
			expQ.delete();
			shadowRegs = '0;
			shadowT    = 1'b0;
			validPipe  = 2'b00;
		end
		else
		begin
			compareField("wbValid", 32'(wbValid), 32'(validPipe[1]));
			if (wbValid === 1'b1)
			begin
				if (expQ.size() == 0)
				begin
					$display("Retire seen with no window in flight");
					errorCount++;
				end
				else
				begin
					gotExp = expQ.pop_front();
					compareField("wbEnA", 32'(wbEnA), 32'(gotExp.enA));
					if (gotExp.enA)
					begin
						compareField("wbRegA", 32'(wbRegA), 32'(gotExp.regA));
						compareField("wbDataA", wbDataA, gotExp.dataA);
					end
					compareField("wbEnB", 32'(wbEnB), 32'(gotExp.enB));
					if (gotExp.enB)
					begin
						compareField("wbRegB", 32'(wbRegB), 32'(gotExp.regB));
						compareField("wbDataB", wbDataB, gotExp.dataB);
					end
					compareField("srT", 32'(srT), 32'(gotExp.nextT));
				end
			end
			else if (wbEnA !== 1'b0 || wbEnB !== 1'b0)
			begin
				$display("Write enable raised in a cycle without a retire");
				errorCount++;
			end
			if (istrValid === 1'b1)
			begin
				predictWindow(istrWord, srWxe, shadowRegs, shadowT, refStep, nextExp);
				compareField("idStep", 32'(idStep), 32'(refStep));
				if (nextExp.enB)
					shadowRegs[{nextExp.regB, 5'd0} +: 32] = nextExp.dataB;
				if (nextExp.enA)
					shadowRegs[{nextExp.regA, 5'd0} +: 32] = nextExp.dataA;
				shadowT = nextExp.nextT;
				expQ.push_back(nextExp);
			end
			validPipe = {validPipe[0], istrValid === 1'b1}; // Two-cycle retire latency
		end
		pendingCount = expQ.size();
	end

endmodule

// ==== bench/wexCoreTb.sv ====
// WEX core testbench driving a seeded random stream of fetch windows
`timescale 1ns/1ps
`include "bjxConsts.svh"

module wexCoreTb;
	import bjxPkg::*;

	localparam int WINDOWS     = 400;
	localparam int DRAIN_LIMIT = 50;

	logic        clock;
	logic        rst;
	logic        istrValid;
	logic [63:0] istrWord;
	logic        srWxe;
	logic [3:0]  idStep;
	logic        wbValid;
	logic        wbEnA;
	regIdx_t     wbRegA;
	word_t       wbDataA;
	logic        wbEnB;
	regIdx_t     wbRegB;
	word_t       wbDataB;
	logic        srT;
	int          errorCount;
	int          pendingCount;
	int          waitCycles;

	wexCore uut (
		.clock(clock), .rst(rst), .istrValid(istrValid), .istrWord(istrWord),
		.srWxe(srWxe), .idStep(idStep), .wbValid(wbValid),
		.wbEnA(wbEnA), .wbRegA(wbRegA), .wbDataA(wbDataA),
		.wbEnB(wbEnB), .wbRegB(wbRegB), .wbDataB(wbDataB), .srT(srT)
	);

	wexCoreChecker retireChecker (
		.clock(clock), .rst(rst), .istrValid(istrValid), .istrWord(istrWord),
		.srWxe(srWxe), .idStep(idStep), .wbValid(wbValid),
		.wbEnA(wbEnA), .wbRegA(wbRegA), .wbDataA(wbDataA),
		.wbEnB(wbEnB), .wbRegB(wbRegB), .wbDataB(wbDataB), .srT(srT),
		.errorCount(errorCount), .pendingCount(pendingCount)
	);

	// Mostly ALU nibbles, a few NOPs
	function automatic logic [15:0] compactOp();
		logic [3:0] nib;
		if ($urandom_range(0, 9) == 0)
			nib = 4'($urandom_range(0, 13));
		else
			nib = 4'($urandom_range(1, 8));
		return {nib, 4'($urandom_range(0, 7)), 4'($urandom_range(0, 7)), 4'($urandom())};
	endfunction

	function automatic logic [31:0] wideOp(input logic [3:0] pfx, input logic bit11);
		logic [15:0] hi;
		if ($urandom_range(0, 3) == 0)
			hi = 16'($urandom()); // Negative immediates and high registers
		else
			hi = {6'($urandom_range(0, 7)), 6'($urandom_range(0, 7)), 4'($urandom())};
		return {hi, pfx, bit11, 3'($urandom()), 2'b00, 6'($urandom_range(0, 7))};
	endfunction

	task automatic nextWindow(output logic [63:0] win, output logic wxe);
		int kind;
		kind = $urandom_range(0, 9);
		wxe  = ($urandom_range(0, 4) != 0);
		case (kind)
			0, 1, 2: win = {$urandom(), 16'($urandom()), compactOp()};
			3, 4:    win = {$urandom(), wideOp(4'($urandom_range(14, 15)), 1'($urandom()))};
			9:       win = {16'($urandom()), compactOp(), wideOp(`JX2_PFX_UNC, 1'b1)};
			default:
				win = {wideOp(4'($urandom_range(14, 15)), 1'($urandom())),
					wideOp(`JX2_PFX_UNC, 1'b1)}; // Bundle
		endcase
	endtask

	task automatic driveWindows(input int count);
		logic [63:0] win;
		logic        wxe;
		for (int n = 0; n < count; n++)
		begin
			nextWindow(win, wxe);
			@(posedge clock);
			istrValid <= 1'b1;
			istrWord  <= win;
			srWxe     <= wxe;
			if ($urandom_range(0, 7) == 0)
			begin
				@(posedge clock);
				istrValid <= 1'b0;
				istrWord  <= {$urandom(), $urandom()};
			end
		end
		@(posedge clock);
		istrValid <= 1'b0;
	endtask

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	initial
	begin
		void'($urandom(32'h4e11_a0c5));
		rst       = 1'b1;
		istrValid = 1'b0;
		istrWord  = '0;
		srWxe     = 1'b0;
		repeat (10) @(posedge clock);
		rst <= 1'b0;
		driveWindows(WINDOWS);
		waitCycles = 0;
		while (pendingCount != 0 && waitCycles < DRAIN_LIMIT)
		begin
			@(posedge clock);
			waitCycles++;
		end
		if (pendingCount != 0)
			$display("Timed out waiting for %0d windows to retire", pendingCount);
		$display("Error count %0d over %0d windows", errorCount, WINDOWS);
		if (errorCount == 0 && pendingCount == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== rtl/bjxConsts.svh ====
// BJX encoding constants for the zero register, op codes, conditions and prefixes
`ifndef BJX_CONSTS_SVH
`define BJX_CONSTS_SVH

`define JX2_GR_ZZR     6'd0 // Zero register

// Op codes in uCmd bits 5:0
`define JX2_OP_NOP     6'd0
`define JX2_OP_ADD     6'd1
`define JX2_OP_SUB     6'd2
`define JX2_OP_AND     6'd3
`define JX2_OP_OR      6'd4
`define JX2_OP_XOR     6'd5
`define JX2_OP_MOVI    6'd6
`define JX2_OP_ADDI    6'd7
`define JX2_OP_CMPEQ   6'd8

// Predicate conditions in uCmd bits 7:6
`define JX2_IXC_AL     2'd0
`define JX2_IXC_CT     2'd1
`define JX2_IXC_CF     2'd2
`define JX2_IXC_NV     2'd3

`define JX2_PFX_PRED   4'hE // Predicated 32-bit op
`define JX2_PFX_UNC    4'hF // Unconditional 32-bit op, bit 11 is WEX

`endif

// ==== rtl/bjxPkg.sv ====
// BJX package holding the vector types shared by decode, execute and writeback
package bjxPkg;

	// Register index, 64 registers with 0 as ZZR
	typedef logic [5:0] regIdx_t;

	// Sign-extended immediate
	typedef logic [32:0] imm_t;

	// Command, condition in 7:6 and op code in 5:0
	typedef logic [7:0] uCmd_t;

	// Command extension, bit 0 picks the immediate over Ro
	typedef logic [7:0] uIxt_t;

	// Register data word
	typedef logic [31:0] word_t;

endpackage

// ==== rtl/bundleDecoder.sv ====
// Bundle decoder that classifies a fetch window and registers the two steered lanes
`timescale 1ns/1ps
`include "bjxConsts.svh"

module bundleDecoder (
	input  logic            clock,
	input  logic            rst,
	input  logic            istrValid,
	input  logic [63:0]     istrWord,
	input  logic            srWxe,
	output logic [3:0]      idStep,
	output logic            decValid,
	output bjxPkg::regIdx_t decRegNA,
	output bjxPkg::regIdx_t decRegMA,
	output bjxPkg::regIdx_t decRegOA,
	output bjxPkg::imm_t    decImmA,
	output bjxPkg::uCmd_t   decUCmdA,
	output bjxPkg::uIxt_t   decUIxtA,
	output bjxPkg::regIdx_t decRegNB,
	output bjxPkg::regIdx_t decRegMB,
	output bjxPkg::regIdx_t decRegOB,
	output bjxPkg::imm_t    decImmB,
	output bjxPkg::uCmd_t   decUCmdB,
	output bjxPkg::uIxt_t   decUIxtB
);
	import bjxPkg::*;

	regIdx_t compRegN, compRegM, compRegO;
	imm_t    compImm;
	uCmd_t   compUCmd;
	uIxt_t   compUIxt;

	regIdx_t slotARegN, slotARegM, slotARegO;
	imm_t    slotAImm;
	uCmd_t   slotAUCmd, slotACmdP;
	uIxt_t   slotAUIxt;
	logic    slotAIsPred, slotAPredFalse, slotAWex;

	regIdx_t slotBRegN, slotBRegM, slotBRegO;
	imm_t    slotBImm;
	uCmd_t   slotBUCmd, slotBCmdP;
	uIxt_t   slotBUIxt;
	logic    slotBIsPred, slotBPredFalse;

	logic    isWideA, isWideB, isBundle;

	regIdx_t nxRegNA, nxRegMA, nxRegOA, nxRegNB, nxRegMB, nxRegOB;
	imm_t    nxImmA, nxImmB;
	uCmd_t   nxUCmdA, nxUCmdB;
	uIxt_t   nxUIxtA, nxUIxtB;

	compactOpDecoder compactDec (
		.opWord(istrWord[15:0]),
		.idRegN(compRegN), .idRegM(compRegM), .idRegO(compRegO),
		.idImm(compImm), .idUCmd(compUCmd), .idUIxt(compUIxt)
	);

	wideOpDecoder wideDecA (
		.opWord(istrWord[31:0]),
		.idRegN(slotARegN), .idRegM(slotARegM), .idRegO(slotARegO),
		.idImm(slotAImm), .idUCmd(slotAUCmd), .idUIxt(slotAUIxt),
		.idIsPred(slotAIsPred), .idPredFalse(slotAPredFalse), .idWex(slotAWex)
	);

	wideOpDecoder wideDecB (
		.opWord(istrWord[63:32]),
		.idRegN(slotBRegN), .idRegM(slotBRegM), .idRegO(slotBRegO),
		.idImm(slotBImm), .idUCmd(slotBUCmd), .idUIxt(slotBUIxt),
		.idIsPred(slotBIsPred), .idPredFalse(slotBPredFalse), .idWex()
	);

	assign isWideA  = (istrWord[15:12] == `JX2_PFX_PRED) || (istrWord[15:12] == `JX2_PFX_UNC);
	assign isWideB  = (istrWord[47:44] == `JX2_PFX_PRED) || (istrWord[47:44] == `JX2_PFX_UNC);
	assign isBundle = isWideA && slotAWex && isWideB && srWxe;
	assign idStep   = isBundle ? 4'd8 : (isWideA ? 4'd4 : 4'd2);

	// Fold the predicate sense into the condition field
	assign slotACmdP = slotAIsPred ?
		{(slotAPredFalse ? `JX2_IXC_CF : `JX2_IXC_CT), slotAUCmd[5:0]} : slotAUCmd;
	assign slotBCmdP = slotBIsPred ?
		{(slotBPredFalse ? `JX2_IXC_CF : `JX2_IXC_CT), slotBUCmd[5:0]} : slotBUCmd;

	always_comb
	begin
		// Scalar filler for lane B
		nxRegNB = `JX2_GR_ZZR;
		nxRegMB = `JX2_GR_ZZR;
		nxRegOB = compRegN;
		nxImmB  = '0;
		nxUCmdB = {`JX2_IXC_AL, `JX2_OP_NOP};
		nxUIxtB = 8'h00;
		if (isBundle)
		begin
			// Lane swap, slot B goes first
			nxRegNA = slotBRegN;
			nxRegMA = slotBRegM;
			nxRegOA = slotBRegO;
			nxImmA  = slotBImm;
			nxUCmdA = slotBCmdP;
			nxUIxtA = slotBUIxt;
			nxRegNB = slotARegN;
			nxRegMB = slotARegM;
			nxRegOB = slotARegO;
			nxImmB  = slotAImm;
			nxUCmdB = slotACmdP;
			nxUIxtB = slotAUIxt;
		end
		else if (isWideA)
		begin
			nxRegNA = slotARegN;
			nxRegMA = slotARegM;
			nxRegOA = slotARegO;
			nxImmA  = slotAImm;
			nxUCmdA = slotACmdP;
			nxUIxtA = slotAUIxt;
			nxRegOB = slotARegN;
		end
		else
		begin
			nxRegNA = compRegN;
			nxRegMA = compRegM;
			nxRegOA = compRegO;
			nxImmA  = compImm;
			nxUCmdA = compUCmd;
			nxUIxtA = compUIxt;
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
			decValid <= 1'b0;
		else
			decValid <= istrValid;
	end

	always_ff @(posedge clock)
	begin
		if (istrValid)
		begin
			decRegNA <= nxRegNA;
			decRegMA <= nxRegMA;
			decRegOA <= nxRegOA;
			decImmA  <= nxImmA;
			decUCmdA <= nxUCmdA;
			decUIxtA <= nxUIxtA;
			decRegNB <= nxRegNB;
			decRegMB <= nxRegMB;
			decRegOB <= nxRegOB;
			decImmB  <= nxImmB;
			decUCmdB <= nxUCmdB;
			decUIxtB <= nxUIxtB;
		end
	end

	// Slot A without prefix F and WEX, or WEX disabled, never forms a bundle
	laneBIdle: assert property (@(posedge clock) disable iff (rst)
		(istrValid && !(srWxe && istrWord[15:11] == {`JX2_PFX_UNC, 1'b1}))
			|=> (decValid && decUCmdB[5:0] == `JX2_OP_NOP))
		else $error("lane B carries an op outside a bundle");

	validKnown: assert property (@(posedge clock) disable iff (rst)
		!$isunknown(istrValid))
		else $error("istrValid is unknown");

endmodule

// ==== rtl/bundleWriteback.sv ====
// Bundle writeback with the register file, the T flag and the retire trace
`timescale 1ns/1ps
`include "bjxConsts.svh"

module bundleWriteback (
	input  logic            clock,
	input  logic            rst,
	input  logic            decValid,
	input  bjxPkg::regIdx_t rdIdxAM,
	input  bjxPkg::regIdx_t rdIdxAO,
	input  bjxPkg::regIdx_t rdIdxBM,
	input  bjxPkg::regIdx_t rdIdxBO,
	input  logic            exWriteA,
	input  bjxPkg::regIdx_t exRegNA,
	input  bjxPkg::word_t   exResultA,
	input  logic            exCmpValidA,
	input  logic            exCmpA,
	input  logic            exWriteB,
	input  bjxPkg::regIdx_t exRegNB,
	input  bjxPkg::word_t   exResultB,
	input  logic            exCmpValidB,
	input  logic            exCmpB,
	output bjxPkg::word_t   rdDataAM,
	output bjxPkg::word_t   rdDataAO,
	output bjxPkg::word_t   rdDataBM,
	output bjxPkg::word_t   rdDataBO,
	output logic            srT,
	output logic            wbValid,
	output logic            wbEnA,
	output bjxPkg::regIdx_t wbRegA,
	output bjxPkg::word_t   wbDataA,
	output logic            wbEnB,
	output bjxPkg::regIdx_t wbRegB,
	output bjxPkg::word_t   wbDataB
);
	import bjxPkg::*;

	word_t gpr [64];
	logic  keepB;

	assign rdDataAM = (rdIdxAM == `JX2_GR_ZZR) ? '0 : gpr[rdIdxAM];
	assign rdDataAO = (rdIdxAO == `JX2_GR_ZZR) ? '0 : gpr[rdIdxAO];
	assign rdDataBM = (rdIdxBM == `JX2_GR_ZZR) ? '0 : gpr[rdIdxBM];
	assign rdDataBO = (rdIdxBO == `JX2_GR_ZZR) ? '0 : gpr[rdIdxBO];

	assign keepB = exWriteB && !(exWriteA && (exRegNA == exRegNB)); // Lane A wins

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			for (int i = 0; i < 64; i++)
				gpr[i] <= '0;
			srT     <= 1'b0;
			wbValid <= 1'b0;
			wbEnA   <= 1'b0;
			wbEnB   <= 1'b0;
		end
		else
		begin
			if (keepB)
				gpr[exRegNB] <= exResultB;
			if (exWriteA)
				gpr[exRegNA] <= exResultA;
			if (exCmpValidA)
				srT <= exCmpA;
			else if (exCmpValidB)
				srT <= exCmpB;
			wbValid <= decValid;
			wbEnA   <= exWriteA;
			wbEnB   <= keepB;
		end
	end

	always_ff @(posedge clock)
	begin
		wbRegA  <= exRegNA;
		wbDataA <= exResultA;
		wbRegB  <= exRegNB;
		wbDataB <= exResultB;
	end

	noZzrWrite: assert property (@(posedge clock) disable iff (rst)
		!(exWriteA && exRegNA == `JX2_GR_ZZR) && !(exWriteB && exRegNB == `JX2_GR_ZZR))
		else $error("write enabled toward ZZR");

endmodule

// ==== rtl/compactOpDecoder.sv ====
// Compact op decoder that maps a 16-bit op onto lane register fields and command
`timescale 1ns/1ps
`include "bjxConsts.svh"

module compactOpDecoder (
	input  logic [15:0]     opWord,
	output bjxPkg::regIdx_t idRegN,
	output bjxPkg::regIdx_t idRegM,
	output bjxPkg::regIdx_t idRegO,
	output bjxPkg::imm_t    idImm,
	output bjxPkg::uCmd_t   idUCmd,
	output bjxPkg::uIxt_t   idUIxt
);
	import bjxPkg::*;

	regIdx_t fieldN;
	regIdx_t fieldM;
	imm_t    immU4;

	assign fieldN = {2'b00, opWord[11:8]};
	assign fieldM = {2'b00, opWord[7:4]};
	assign immU4  = {29'd0, opWord[3:0]};

	always_comb
	begin
		idRegN = fieldN;
		idRegM = fieldN; // Rn is also the first source
		idRegO = fieldM;
		idImm  = immU4;
		idUIxt = 8'h00;
		idUCmd = {`JX2_IXC_AL, `JX2_OP_NOP};
		case (opWord[15:12])
			4'h1: idUCmd = {`JX2_IXC_AL, `JX2_OP_ADD};
			4'h2: idUCmd = {`JX2_IXC_AL, `JX2_OP_SUB};
			4'h3: idUCmd = {`JX2_IXC_AL, `JX2_OP_AND};
			4'h4: idUCmd = {`JX2_IXC_AL, `JX2_OP_OR};
			4'h5: idUCmd = {`JX2_IXC_AL, `JX2_OP_XOR};
			4'h6:
			begin
				idUCmd = {`JX2_IXC_AL, `JX2_OP_MOVI};
				idUIxt = 8'h01;
			end
			4'h7:
			begin
				idUCmd = {`JX2_IXC_AL, `JX2_OP_ADDI};
				idUIxt = 8'h01;
			end
			4'h8: idUCmd = {`JX2_IXC_AL, `JX2_OP_CMPEQ}; // Rn == Rm
			default:
			begin
				// 0 and 9..D decode as NOP
				idRegN = `JX2_GR_ZZR;
			end
		endcase
	end

endmodule

// ==== rtl/laneAlu.sv ====
// Execute lane ALU that checks the predicate and computes result, write and compare
`timescale 1ns/1ps
`include "bjxConsts.svh"

module laneAlu (
	input  logic            decValid,
	input  bjxPkg::uCmd_t   decUCmd,
	input  bjxPkg::uIxt_t   decUIxt,
	input  bjxPkg::imm_t    decImm,
	input  bjxPkg::regIdx_t decRegN,
	input  bjxPkg::word_t   srcM,
	input  bjxPkg::word_t   srcO,
	input  logic            srT,
	output logic            exWrite,
	output bjxPkg::regIdx_t exRegN,
	output bjxPkg::word_t   exResult,
	output logic            exCmpValid,
	output logic            exCmp
);
	import bjxPkg::*;

	logic [1:0] cond;
	logic [5:0] op;
	logic       condPass;
	logic       active;
	logic       writeOp;
	word_t      opB;

	assign cond = decUCmd[7:6];
	assign op   = decUCmd[5:0];
	assign opB  = decUIxt[0] ? decImm[31:0] : srcO;

	assign condPass = (cond == `JX2_IXC_AL) ||
		((cond == `JX2_IXC_CT) && srT) ||
		((cond == `JX2_IXC_CF) && !srT); // NV never passes
	assign active = decValid && condPass;

	always_comb
	begin
		writeOp  = 1'b1;
		exResult = '0;
		case (op)
			`JX2_OP_ADD:  exResult = srcM + opB;
			`JX2_OP_SUB:  exResult = srcM - opB;
			`JX2_OP_AND:  exResult = srcM & opB;
			`JX2_OP_OR:   exResult = srcM | opB;
			`JX2_OP_XOR:  exResult = srcM ^ opB;
			`JX2_OP_MOVI: exResult = opB;
			`JX2_OP_ADDI: exResult = srcM + opB;
			default:      writeOp = 1'b0; // NOP and CMPEQ
		endcase
	end

	assign exRegN     = decRegN;
	assign exWrite    = active && writeOp && (decRegN != `JX2_GR_ZZR);
	assign exCmpValid = active && (op == `JX2_OP_CMPEQ);
	assign exCmp      = (srcM == opB);

endmodule

// ==== rtl/wexCore.sv ====
// Two-wide WEX core joining the bundle decoder, two lane ALUs and writeback
`timescale 1ns/1ps

module wexCore (
	input  logic            clock,
	input  logic            rst,
	input  logic            istrValid,
	input  logic [63:0]     istrWord,
	input  logic            srWxe,
	output logic [3:0]      idStep,
	output logic            wbValid,
	output logic            wbEnA,
	output bjxPkg::regIdx_t wbRegA,
	output bjxPkg::word_t   wbDataA,
	output logic            wbEnB,
	output bjxPkg::regIdx_t wbRegB,
	output bjxPkg::word_t   wbDataB,
	output logic            srT
);
	import bjxPkg::*;

	logic    decValid;
	regIdx_t decRegNA, decRegMA, decRegOA, decRegNB, decRegMB, decRegOB;
	imm_t    decImmA, decImmB;
	uCmd_t   decUCmdA, decUCmdB;
	uIxt_t   decUIxtA, decUIxtB;
	word_t   rdDataAM, rdDataAO, rdDataBM, rdDataBO;
	logic    exWriteA, exCmpValidA, exCmpA;
	logic    exWriteB, exCmpValidB, exCmpB;
	regIdx_t exRegNA, exRegNB;
	word_t   exResultA, exResultB;

	bundleDecoder bundleDec (
		.clock(clock), .rst(rst), .istrValid(istrValid), .istrWord(istrWord),
		.srWxe(srWxe), .idStep(idStep), .decValid(decValid),
		.decRegNA(decRegNA), .decRegMA(decRegMA), .decRegOA(decRegOA),
		.decImmA(decImmA), .decUCmdA(decUCmdA), .decUIxtA(decUIxtA),
		.decRegNB(decRegNB), .decRegMB(decRegMB), .decRegOB(decRegOB),
		.decImmB(decImmB), .decUCmdB(decUCmdB), .decUIxtB(decUIxtB)
	);

	laneAlu laneA (
		.decValid(decValid), .decUCmd(decUCmdA), .decUIxt(decUIxtA),
		.decImm(decImmA), .decRegN(decRegNA), .srcM(rdDataAM), .srcO(rdDataAO),
		.srT(srT), .exWrite(exWriteA), .exRegN(exRegNA), .exResult(exResultA),
		.exCmpValid(exCmpValidA), .exCmp(exCmpA)
	);

	laneAlu laneB (
		.decValid(decValid), .decUCmd(decUCmdB), .decUIxt(decUIxtB),
		.decImm(decImmB), .decRegN(decRegNB), .srcM(rdDataBM), .srcO(rdDataBO),
		.srT(srT), .exWrite(exWriteB), .exRegN(exRegNB), .exResult(exResultB),
		.exCmpValid(exCmpValidB), .exCmp(exCmpB)
	);

	bundleWriteback writeback (
		.clock(clock), .rst(rst), .decValid(decValid),
		.rdIdxAM(decRegMA), .rdIdxAO(decRegOA), .rdIdxBM(decRegMB), .rdIdxBO(decRegOB),
		.exWriteA(exWriteA), .exRegNA(exRegNA), .exResultA(exResultA),
		.exCmpValidA(exCmpValidA), .exCmpA(exCmpA),
		.exWriteB(exWriteB), .exRegNB(exRegNB), .exResultB(exResultB),
		.exCmpValidB(exCmpValidB), .exCmpB(exCmpB),
		.rdDataAM(rdDataAM), .rdDataAO(rdDataAO), .rdDataBM(rdDataBM), .rdDataBO(rdDataBO),
		.srT(srT), .wbValid(wbValid),
		.wbEnA(wbEnA), .wbRegA(wbRegA), .wbDataA(wbDataA),
		.wbEnB(wbEnB), .wbRegB(wbRegB), .wbDataB(wbDataB)
	);

endmodule

// ==== rtl/wideOpDecoder.sv ====
// Wide op decoder that splits one 32-bit op into lane fields and predicate flags
`timescale 1ns/1ps
`include "bjxConsts.svh"

module wideOpDecoder (
	input  logic [31:0]     opWord,
	output bjxPkg::regIdx_t idRegN,
	output bjxPkg::regIdx_t idRegM,
	output bjxPkg::regIdx_t idRegO,
	output bjxPkg::imm_t    idImm,
	output bjxPkg::uCmd_t   idUCmd,
	output bjxPkg::uIxt_t   idUIxt,
	output logic            idIsPred,
	output logic            idPredFalse,
	output logic            idWex
);
	import bjxPkg::*;

	logic [3:0] prefix;
	logic [5:0] opCode;
	regIdx_t    fieldN;
	regIdx_t    fieldM;
	regIdx_t    fieldO;
	imm_t       immS16;

	assign prefix = opWord[15:12];
	assign opCode = {3'b000, opWord[10:8]} + 6'd1; // Field holds op minus one
	assign fieldN = opWord[5:0];
	assign fieldM = opWord[31:26];
	assign fieldO = opWord[25:20];
	assign immS16 = {{17{opWord[31]}}, opWord[31:16]};

	// Bit 11 is the sense for E and WEX for F
	assign idIsPred    = (prefix == `JX2_PFX_PRED);
	assign idPredFalse = (prefix == `JX2_PFX_PRED) && opWord[11];
	assign idWex       = (prefix == `JX2_PFX_UNC) && opWord[11];

	always_comb
	begin
		idRegN = fieldN;
		idImm  = immS16;
		idUCmd = {`JX2_IXC_AL, opCode}; // Condition filled in by the bundle decoder
		case (opCode)
			`JX2_OP_MOVI, `JX2_OP_ADDI:
			begin
				// Immediate overlaps Rm/Ro, so Rn is the source
				idRegM = fieldN;
				idRegO = `JX2_GR_ZZR;
				idUIxt = 8'h01;
			end
			default:
			begin
				idRegM = fieldM;
				idRegO = fieldO;
				idUIxt = 8'h00;
			end
		endcase
	end

endmodule

// ==== wexCore.f ====
+incdir+rtl
rtl/bjxPkg.sv
rtl/compactOpDecoder.sv
rtl/wideOpDecoder.sv
rtl/bundleDecoder.sv
rtl/laneAlu.sv
rtl/bundleWriteback.sv
rtl/wexCore.sv
bench/wexCoreChecker.sv
bench/wexCoreTb.sv
